// ==== hw/lcdPkg.sv ====
package lcdPkg;

	// HD44780 instruction bytes, 8-bit bus
	localparam logic [7:0] cmdFunctionSet = 8'h38; // 8-bit bus, two lines, 5x8 font
	localparam logic [7:0] cmdDisplayOn = 8'h0C;   // Display on, cursor off
	localparam logic [7:0] cmdClear = 8'h01;       // Clear and home
	localparam logic [7:0] cmdEntryMode = 8'h06;   // Increment, no shift

	// Power-on order is function set, display on, clear, entry mode
	localparam int initCmdCount = 4;
	localparam int initIdxWidth = $clog2(initCmdCount);

	// Bus timing in clock cycles, short values for simulation
	localparam int enableCycles = 4;     // lcdE high time
	localparam int powerOnCycles = 200;  // Idle after reset
	localparam int shortWaitCycles = 40; // After most commands and data writes
	localparam int clearWaitCycles = 160; // After a clear

	// One counter covers every wait, so it is sized by the longest one
	localparam int maxWaitCycles = (powerOnCycles > clearWaitCycles) ?
		powerOnCycles : clearWaitCycles;
	localparam int waitWidth = $clog2(maxWaitCycles + 1);

	typedef enum logic [2:0]
	{
		powerWait, // Counting down the power-on delay
		initPulse, // Enable pulse of a power-on command
		initWait,  // Command wait during power-on
		ready,     // Waiting for a clear or a write
		pulse,     // Enable pulse of a runtime transfer
		hold       // Command or data wait at runtime
	} lcdCtrlState;

endpackage

// ==== hw/displayPkg.sv ====
package displayPkg;

	localparam int charCount = 6; // A hi, A lo, X hi, X lo, Y hi, Y lo
	localparam int charIdxWidth = $clog2(charCount);

	typedef enum logic [2:0]
	{
		idle,      // Waiting for display
		clearReq,  // clrLCD held until the controller takes it
		waitClear, // Clear in progress
		sendChar,  // writeStart pulse
		waitChar,  // Waiting for writeDone
		finish     // Done, waiting for display to drop
	} dispState;

	// Uppercase hex digit
	function automatic logic [7:0] hexToAscii(input logic [3:0] nibble);
		logic [7:0] wide;
		wide = {4'h0, nibble};
		if (nibble < 4'd10)
		begin
			return 8'h30 + wide; // '0' to '9'
		end
		return 8'h41 + (wide - 8'd10); // 'A' to 'F'
	endfunction

endpackage

// ==== hw/lcdCmdIf.sv ====
interface lcdCmdIf;

	logic [7:0] data;  // ASCII byte for a write
	logic writeStart;  // One-cycle request
	logic clrLCD;      // Level request, held until initDone falls
	logic initDone;    // High while the controller is idle and initialised
	logic writeDone;   // One-cycle completion of a write

	modport seq
	(
		output data, writeStart, clrLCD,
		input initDone, writeDone
	);

	modport ctrl
	(
		input data, writeStart, clrLCD,
		output initDone, writeDone
	);

endinterface

// ==== hw/regDisplayFsm.sv ====
module regDisplayFsm
(
	input logic clkFSM,
	input logic resetFSM,
	input logic display,
	input logic [7:0] regA,
	input logic [7:0] regX,
	input logic [7:0] regY,
	lcdCmdIf.seq cmd
);
	import displayPkg::*;

	dispState state;
	logic [charIdxWidth-1:0] charIdx; // Which nibble goes out next
	logic [charCount*4-1:0] snapshot;  // {A, X, Y} as seen when display rose
	logic [3:0] nibble;
	logic startReq;
	logic lastChar;

	// A display can only start once the LCD is initialised
	assign startReq = cmd.initDone && display;

	// Character 0 is the top nibble of A
	assign nibble = snapshot[(charCount - 1 - int'(charIdx)) * 4 +: 4];

	assign lastChar = (charIdx == charIdxWidth'(charCount - 1));

	// Snapshot and outgoing byte
	always_ff @(posedge clkFSM)
	begin
		if (state == idle && startReq)
		begin
			snapshot <= {regA, regX, regY}; // Later register changes are ignored
		end
		if (state == sendChar)
		begin
			cmd.data <= hexToAscii(nibble); // Stays put until writeDone
		end
	end

	// Sequence control
	always_ff @(posedge clkFSM)
	begin
		if (resetFSM)
		begin
			state <= idle;
			charIdx <= '0;
			cmd.writeStart <= 1'b0;
			cmd.clrLCD <= 1'b0;
		end
		else
		begin
			cmd.writeStart <= 1'b0; // Pulse by default
			case (state)
				idle:
				begin
					if (startReq)
					begin
						cmd.clrLCD <= 1'b1;
						state <= clearReq;
					end
				end
				clearReq:
				begin
					if (!cmd.initDone)
					begin
						cmd.clrLCD <= 1'b0; // Controller has taken the clear
						state <= waitClear;
					end
				end
				waitClear:
				begin
					if (cmd.initDone)
					begin
						charIdx <= '0;
						state <= sendChar;
					end
				end
				sendChar:
				begin
					cmd.writeStart <= 1'b1;
					state <= waitChar;
				end
				waitChar:
				begin
					if (cmd.writeDone)
					begin
						if (lastChar)
						begin
							state <= finish;
						end
						else
						begin
							charIdx <= charIdx + 1'b1;
							state <= sendChar;
						end
					end
				end
				finish:
				begin
					if (!display)
					begin
						state <= idle; // Rearm on the next rising display
					end
				end
				default:
				begin
					state <= idle;
				end
			endcase
		end
	end

endmodule

// ==== hw/lcdController.sv ====
module lcdController
(
	input logic clkFSM,
	input logic resetFSM,
	lcdCmdIf.ctrl cmd,
	output logic lcdRs,
	output logic lcdRw,
	output logic lcdE,
	output logic [7:0] lcdData
);
	import lcdPkg::*;

	lcdCtrlState state;
	logic [waitWidth-1:0] waitCnt;     // Shared by every wait and the enable pulse
	logic [initIdxWidth-1:0] initIdx;  // Current power-on command
	logic [waitWidth-1:0] postWait;

	// Power-on command table
	function automatic logic [7:0] initCmdOf(input logic [initIdxWidth-1:0] idx);
		case (idx)
			2'd0: return cmdFunctionSet;
			2'd1: return cmdDisplayOn;
			2'd2: return cmdClear;
			default: return cmdEntryMode;
		endcase
	endfunction

	assign lcdRw = 1'b0; // Write only, busy flag is never read

	// Clear needs the long wait whether it comes from power-on or a request
	assign postWait = (!lcdRs && lcdData == cmdClear) ?
		waitWidth'(clearWaitCycles - 1) : waitWidth'(shortWaitCycles - 1);

	always_ff @(posedge clkFSM)
	begin
		if (resetFSM)
		begin
			state <= powerWait;
			waitCnt <= waitWidth'(powerOnCycles - 2); // lcdE rises powerOnCycles later
			initIdx <= '0;
			lcdE <= 1'b0;
			lcdRs <= 1'b0;
			cmd.initDone <= 1'b0;
			cmd.writeDone <= 1'b0;
		end
		else
		begin
			cmd.writeDone <= 1'b0; // Pulse by default
			case (state)
				powerWait:
				begin
					if (waitCnt == '0)
					begin
						lcdData <= initCmdOf(initIdx); // Setup cycle before lcdE
						state <= initPulse;
					end
					else
					begin
						waitCnt <= waitCnt - 1'b1;
					end
				end
				initPulse, pulse:
				begin
					if (!lcdE)
					begin
						lcdE <= 1'b1; // Bus was set up last cycle
						waitCnt <= waitWidth'(enableCycles - 1);
					end
					else if (waitCnt == '0)
					begin
						lcdE <= 1'b0; // LCD latches on this edge
						waitCnt <= postWait;
						state <= (state == initPulse) ? initWait : hold;
					end
					else
					begin
						waitCnt <= waitCnt - 1'b1;
					end
				end
				initWait:
				begin
					if (waitCnt != '0)
					begin
						waitCnt <= waitCnt - 1'b1;
					end
					else if (initIdx == initIdxWidth'(initCmdCount - 1))
					begin
						cmd.initDone <= 1'b1; // Power-on sequence complete
						state <= ready;
					end
					else
					begin
						initIdx <= initIdx + 1'b1;
						lcdData <= initCmdOf(initIdx + 1'b1);
						state <= initPulse;
					end
				end
				ready:
				begin
					if (cmd.clrLCD)
					begin
						cmd.initDone <= 1'b0; // Low until the clear wait ends
						lcdRs <= 1'b0;
						lcdData <= cmdClear;
						state <= pulse;
					end
					else if (cmd.writeStart)
					begin
						lcdRs <= 1'b1; // Data register
						lcdData <= cmd.data;
						state <= pulse;
					end
				end
				hold:
				begin
					if (waitCnt != '0)
					begin
						waitCnt <= waitCnt - 1'b1;
					end
					else
					begin
						state <= ready;
						if (lcdRs)
						begin
							cmd.writeDone <= 1'b1; // Character written
						end
						else
						begin
							cmd.initDone <= 1'b1; // Clear finished
						end
					end
				end
				default:
				begin
					state <= powerWait;
				end
			endcase
		end
	end

endmodule

// ==== hw/lcdRegDisplay.sv ====
module lcdRegDisplay
(
	input logic clkFSM,
	input logic resetFSM,
	input logic display,
	input logic [7:0] regA,
	input logic [7:0] regX,
	input logic [7:0] regY,
	output logic lcdRs,
	output logic lcdRw,
	output logic lcdE,
	output logic [7:0] lcdData
);

	lcdCmdIf cmdBus (); // Sequencer to controller requests

	regDisplayFsm uRegDisplayFsm
	(
		.clkFSM(clkFSM),
		.resetFSM(resetFSM),
		.display(display),
		.regA(regA),
		.regX(regX),
		.regY(regY),
		.cmd(cmdBus.seq)
	);

	lcdController uLcdController
	(
		.clkFSM(clkFSM),
		.resetFSM(resetFSM),
		.cmd(cmdBus.ctrl),
		.lcdRs(lcdRs),
		.lcdRw(lcdRw),
		.lcdE(lcdE),
		.lcdData(lcdData)
	);

endmodule

// ==== test/lcdBusMonitor.sv ====
module lcdBusMonitor
(
	input logic clkFSM,
	input logic lcdE,
	input logic lcdRs,
	input logic lcdRw,
	input logic [7:0] lcdData
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [16:0] xferQ[$]; // {rs, data, high cycles}, oldest first
	int highCnt = 0;
	bit rwSeen = 1'b0;     // Set once lcdRw is seen high

	// LCD outputs change just after the rising edge
	always @(negedge clkFSM)
	begin
		if (lcdE === 1'b1)
		begin
			highCnt++;
		end
		if (lcdRw !== 1'b0)
		begin
			rwSeen = 1'b1;
		end
	end

	// The LCD latches rs and data when lcdE falls
	always @(negedge lcdE)
	begin
		if (highCnt > 0) // Skips the X to 0 change at start-up
		begin
			xferQ.push_back({lcdRs, lcdData, 8'(highCnt)});
			highCnt = 0;
		end
	end

endmodule

// ==== test/tbLcdRegDisplay.sv ====
module tbLcdRegDisplay;
	timeunit 1ns;
	timeprecision 1ps;
	import lcdPkg::*;

	localparam int halfPeriod = 50;   // 100 ns clock
	localparam int resetCycles = 4;
	localparam int xferTimeout = 1000; // Cycles allowed for one transfer

	logic clkFSM;
	logic resetFSM;
	logic display;
	logic [7:0] regA;
	logic [7:0] regX;
	logic [7:0] regY;
	logic lcdRs;
	logic lcdRw;
	logic lcdE;
	logic [7:0] lcdData;
	int errCount = 0;
	int testCount = 0;
	int failCount = 0;
	int widthLog[$]; // High time of every transfer checked so far

	lcdRegDisplay u_dut
	(
		.clkFSM(clkFSM),
		.resetFSM(resetFSM),
		.display(display),
		.regA(regA),
		.regX(regX),
		.regY(regY),
		.lcdRs(lcdRs),
		.lcdRw(lcdRw),
		.lcdE(lcdE),
		.lcdData(lcdData)
	);

	lcdBusMonitor uMonitor
	(
		.clkFSM(clkFSM),
		.lcdE(lcdE),
		.lcdRs(lcdRs),
		.lcdRw(lcdRw),
		.lcdData(lcdData)
	);

	initial
	begin
		clkFSM = 1'b0;
		forever #(halfPeriod) clkFSM = ~clkFSM;
	end

	// Uppercase ASCII hex digit
	function automatic logic [7:0] expectedHexChar(input logic [3:0] n);
		if (n < 4'd10)
		begin
			return "0" + n;
		end
		return "A" + (n - 4'd10);
	endfunction

	function automatic logic [47:0] expectedText(input logic [7:0] a, x, y);
		return {expectedHexChar(a[7:4]), expectedHexChar(a[3:0]), expectedHexChar(x[7:4]),
			expectedHexChar(x[3:0]), expectedHexChar(y[7:4]), expectedHexChar(y[3:0])};
	endfunction

	task automatic recordTimeout(input string what);
		$display("Timeout at %0t: no LCD transfer arrived for the %s", $time, what);
		errCount++;
	endtask

	task automatic expectTransfer(input logic expRs, input logic [7:0] expData,
		input string what);
		logic rs;
		logic [7:0] data;
		logic [7:0] width;
		int waited;
		waited = 0;
		while (uMonitor.xferQ.size() == 0 && waited < xferTimeout)
		begin
			@(negedge clkFSM);
			waited++;
		end
		if (uMonitor.xferQ.size() == 0)
		begin
			recordTimeout(what);
		end
		else
		begin
			{rs, data, width} = uMonitor.xferQ.pop_front();
			widthLog.push_back(int'(width)); // Checked by enableWidth
			if (rs !== expRs || data !== expData)
			begin
				$display("ERR %0t: %s expected rs=%0b data=%h, got rs=%0b data=%h",
					$time, what, expRs, expData, rs, data);
				errCount++;
			end
		end
	endtask

	// Six characters with the first in the top byte
	task automatic expectText(input logic [47:0] text);
		for (int i = 5; i >= 0; i--)
		begin
			expectTransfer(1'b1, text[i*8 +: 8], "character");
		end
	endtask

	task automatic startDisplay(input logic [7:0] a, x, y);
		@(negedge clkFSM);
		regA = a;
		regX = x;
		regY = y;
		display = 1'b1;
	endtask

	// Display drops once the last character wait has run out
	task automatic endDisplay();
		repeat (shortWaitCycles + 4) @(negedge clkFSM);
		display = 1'b0;
		repeat (2) @(negedge clkFSM);
	endtask

	task automatic reportTest(input string name, input int errBefore);
		testCount++;
		if (errCount == errBefore)
		begin
			$display("%s: PASS", name);
		end
		else
		begin
			$display("%s: FAIL", name);
			failCount++;
		end
	endtask

	task automatic initSequence();
		int errBefore = errCount;
		expectTransfer(1'b0, cmdFunctionSet, "function set command");
		expectTransfer(1'b0, cmdDisplayOn, "display on command");
		expectTransfer(1'b0, cmdClear, "power-on clear command");
		expectTransfer(1'b0, cmdEntryMode, "entry mode command");
		if (uMonitor.rwSeen)
		begin
			$display("ERR %0t: lcdRw was driven high", $time);
			errCount++;
		end
		reportTest("initSequence", errBefore);
	endtask

	task automatic fixedDisplay();
		int errBefore = errCount;
		startDisplay(8'h18, 8'h54, 8'h5A);
		expectTransfer(1'b0, cmdClear, "clear command");
		expectText("18545A");
		endDisplay();
		reportTest("fixedDisplay", errBefore);
	endtask

	task automatic holdAndRetrigger();
		int errBefore = errCount;
		startDisplay(8'hC3, 8'h0F, 8'hE7);
		expectTransfer(1'b0, cmdClear, "clear command");
		expectText(expectedText(8'hC3, 8'h0F, 8'hE7));
		repeat (4 * clearWaitCycles) @(negedge clkFSM); // display stays high
		if (uMonitor.xferQ.size() != 0)
		begin
			$display("ERR %0t: %0d transfers while display was held",
				$time, uMonitor.xferQ.size());
			errCount++;
			uMonitor.xferQ.delete();
		end
		endDisplay();
		startDisplay(8'h90, 8'hB2, 8'h7D);
		expectTransfer(1'b0, cmdClear, "clear command");
		expectText(expectedText(8'h90, 8'hB2, 8'h7D));
		endDisplay();
		reportTest("holdAndRetrigger", errBefore);
	endtask

	task automatic snapshotStable();
		int errBefore = errCount;
		startDisplay(8'h3C, 8'hA5, 8'h96);
		expectTransfer(1'b0, cmdClear, "clear command");
		regA = 8'hFF; // Too late to matter
		regX = 8'h00;
		regY = 8'h11;
		expectText(expectedText(8'h3C, 8'hA5, 8'h96));
		endDisplay();
		reportTest("snapshotStable", errBefore);
	endtask

	task automatic randomDisplays();
		int errBefore = errCount;
		logic [7:0] a;
		logic [7:0] x;
		logic [7:0] y;
		repeat (8)
		begin
			a = 8'($urandom);
			x = 8'($urandom);
			y = 8'($urandom);
			startDisplay(a, x, y);
			expectTransfer(1'b0, cmdClear, "clear command");
			expectText(expectedText(a, x, y));
			endDisplay();
		end
		reportTest("randomDisplays", errBefore);
	endtask

	task automatic enableWidth();
		int errBefore = errCount;
		if (widthLog.size() == 0)
		begin
			$display("No LCD transfers were recorded, enable width cannot be checked");
			errCount++;
		end
		foreach (widthLog[i])
		begin
			if (widthLog[i] != enableCycles)
			begin
				$display("ERR %0t: transfer %0d held lcdE for %0d cycles, expected %0d",
					$time, i, widthLog[i], enableCycles);
				errCount++;
			end
		end
		reportTest("enableWidth", errBefore);
	endtask

	initial
	begin
		void'($urandom(32'h2a94));
		resetFSM = 1'b1;
		display = 1'b0;
		regA = 8'h00;
		regX = 8'h00;
		regY = 8'h00;
		repeat (resetCycles) @(negedge clkFSM);
		resetFSM = 1'b0;
		initSequence();
		fixedDisplay();
		holdAndRetrigger();
		snapshotStable();
		randomDisplays();
		enableWidth();
		$display("Tests run: %0d, failed: %0d, errors: %0d", testCount, failCount, errCount);
		if (errCount == 0)
		begin
			$display("No errors");
		end
		else
		begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// ==== all.f ====
hw/lcdPkg.sv
hw/displayPkg.sv
hw/lcdCmdIf.sv
hw/regDisplayFsm.sv
hw/lcdController.sv
hw/lcdRegDisplay.sv
test/lcdBusMonitor.sv
test/tbLcdRegDisplay.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
	--top-module tbLcdRegDisplay -f all.f -o simLcd > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "Verilator build failed, see build.log"
	exit 1
fi

./obj_dir/simLcd > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "Simulation exited abnormally, see sim.log"
	exit 1
fi

if grep -qx "No errors" sim.log; then
	echo "PASS"
	exit 0
fi
echo "FAIL, see sim.log"
exit 1
